// File: list.f
src/sdram_geom_pkg.sv
src/sdram_cmd_pkg.sv
src/host_intake.sv
src/bank_queue.sv
src/bank_tracker.sv
src/cmd_arbiter.sv
src/sdram_sched_top.sv
testbench/tb_sdram_sched.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_sdram_sched
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: testbench/tb_sdram_sched.sv
// Testbench for the SDRAM command scheduler with random host traffic, a bank model and scoreboard
`timescale 1ns/10ps

module tb_sdram_sched;

    localparam logic [15:0] SEED    = 16'd37;
    localparam int NUM_REQ          = 40;
    localparam int ACK_TIMEOUT      = 200;
    localparam int DRAIN_TIMEOUT    = 4000;
    localparam int SB_DEPTH         = 64;
    localparam int FILL_WAIT        = 6;   // Cycles a request is held off by the full queue

    logic clk_in, rst_in, req, write_in, cmd_ready, ack, valid_out;
    logic [sdram_geom_pkg::BG_W-1:0]     bank_group_in, bank_group_out;
    logic [sdram_geom_pkg::BA_W-1:0]     bank_in, bank_out;
    logic [sdram_geom_pkg::ROW_BITS-1:0] row_in, row_out;
    logic [sdram_geom_pkg::COL_BITS-1:0] col_in, col_out;
    logic [sdram_geom_pkg::DATA_W-1:0]   val_in, val_out;
    sdram_cmd_pkg::cmd_t                 cmd_out;

    // Bank model built from the command bus alone
    logic [sdram_geom_pkg::BANKS-1:0]                               model_open;
    logic [sdram_geom_pkg::BANKS-1:0][sdram_geom_pkg::ROW_BITS-1:0] model_row;
    int last_cyc [sdram_geom_pkg::BANKS];
    int min_gap [sdram_geom_pkg::BANKS];
    int cyc;

    // Per-bank scoreboard of accepted requests with the oldest at sb_head
    sdram_cmd_pkg::req_t sb_mem [sdram_geom_pkg::BANKS][SB_DEPTH];
    int sb_head [sdram_geom_pkg::BANKS];
    int sb_tail [sdram_geom_pkg::BANKS];
    int accepted, completed, err_count;

    logic quiet_phase, expect_no_ack, rand_ready;
    bit timeout_hit;
    logic [15:0] lfsr;
    sdram_cmd_pkg::req_t cur_req;
    logic [sdram_geom_pkg::BANK_IDX_W-1:0] cur_idx;

    logic [sdram_geom_pkg::BANK_IDX_W-1:0]   out_idx;
    logic                                    col_cmd, exp_avail, open_at_out;
    logic [sdram_geom_pkg::ROW_BITS-1:0]     row_at_out;
    int                                      gap_out, min_gap_out;
    sdram_cmd_pkg::req_t                     exp_req;
    logic [$bits(sdram_cmd_pkg::req_t)-1:0]  exp_word, act_word;

    assign out_idx     = {bank_group_out, bank_out};
    assign col_cmd     = valid_out && (cmd_out == sdram_cmd_pkg::READ ||
                                       cmd_out == sdram_cmd_pkg::WRITE);
    assign open_at_out = model_open[out_idx];
    assign row_at_out  = model_row[out_idx];
    assign gap_out     = cyc - last_cyc[out_idx];
    assign min_gap_out = min_gap[out_idx];
    assign exp_avail   = sb_head[out_idx] < sb_tail[out_idx];
    assign exp_req     = sb_mem[out_idx][sb_head[out_idx]];
    // Reads carry zero data on the bus
    assign exp_word = {exp_req.row, exp_req.col, exp_req.write,
                       exp_req.data & {sdram_geom_pkg::DATA_W{exp_req.write}}};
    assign act_word = {row_out, col_out, cmd_out == sdram_cmd_pkg::WRITE, val_out};

    sdram_sched_top i_dut (.*);

    always #20 clk_in = ~clk_in;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // x^16 + x^14 + x^13 + x^11 + 1
    endfunction

    task automatic draw_bits(input int count, output logic [15:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr = lfsr_next(lfsr);
            bits = {bits[14:0], lfsr[0]};
        end
    endtask

    task automatic report_mismatch(input string test, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
        err_count++;
        $display("ERR %s expected 0x%0h actual 0x%0h", test, exp_v, act_v);
    endtask

    task automatic report_failure(input string what);
        err_count++;
        $display("Check failed: %s", what);
    endtask

    task automatic finish_run(input bit timed_out);
        $display("Errors: %0d, timeouts: %0d, completed %0d of %0d requests",
                 err_count, timed_out, completed, accepted);
        if (err_count == 0 && !timed_out) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    endtask

    // One clock with the controller ready three cycles out of four once released
    task automatic step_cycle();
        logic [15:0] r;
        @(posedge clk_in);
        if (rand_ready) begin
            draw_bits(2, r);
            cmd_ready <= r[0] | r[1];
        end
    endtask

    task automatic present_req(input logic [sdram_geom_pkg::BANK_IDX_W-1:0] idx);
        logic [15:0] r;
        cur_req = '0;
        draw_bits(3, r);
        cur_req.row[2:0] = r[2:0];   // Few rows, so hits and misses both occur
        draw_bits(sdram_geom_pkg::COL_BITS, r);
        cur_req.col = r[sdram_geom_pkg::COL_BITS-1:0];
        draw_bits(1, r);
        cur_req.write = r[0];
        draw_bits(sdram_geom_pkg::DATA_W, r);
        cur_req.data = r[sdram_geom_pkg::DATA_W-1:0];
        cur_idx = idx;
        bank_group_in <= idx[sdram_geom_pkg::BANK_IDX_W-1:sdram_geom_pkg::BA_W];
        bank_in       <= idx[sdram_geom_pkg::BA_W-1:0];
        row_in        <= cur_req.row;
        col_in        <= cur_req.col;
        write_in      <= cur_req.write;
        val_in        <= cur_req.data;
        req           <= 1'b1;
    endtask

    task automatic wait_for_ack();
        int n;
        n = 0;
        if (timeout_hit) begin
            return;
        end
        step_cycle();
        while (!ack && n < ACK_TIMEOUT) begin
            step_cycle();
            n++;
        end
        if (!ack) begin
            $display("Timeout: bank %0d gave no ack within %0d cycles", cur_idx, ACK_TIMEOUT);
            timeout_hit = 1'b1;
        end
    endtask

    task automatic release_req();
        int n;
        n = 0;
        if (timeout_hit) begin
            return;
        end
        sb_mem[cur_idx][sb_tail[cur_idx]] <= cur_req;
        sb_tail[cur_idx] <= sb_tail[cur_idx] + 1;
        accepted = accepted + 1;
        req <= 1'b0;
        step_cycle();
        while (ack && n < ACK_TIMEOUT) begin
            step_cycle();
            n++;
        end
        if (ack) begin
            $display("Timeout: ack stayed high %0d cycles after req was released", ACK_TIMEOUT);
            timeout_hit = 1'b1;
        end
    endtask

    // Follow every bus command to update the bank model and the scoreboard
    always @(posedge clk_in) begin
        if (rst_in) begin
            cyc        <= 0;
            completed  <= 0;
            model_open <= '0;
            for (int b = 0; b < sdram_geom_pkg::BANKS; b++) begin
                last_cyc[b] <= 0;
                min_gap[b]  <= 0;
                sb_head[b]  <= 0;
            end
        end else begin
            cyc <= cyc + 1;
            if (valid_out) begin
                last_cyc[out_idx] <= cyc;
                case (cmd_out)
                    sdram_cmd_pkg::ACTIVATE: begin
                        model_open[out_idx] <= 1'b1;
                        model_row[out_idx]  <= row_out;
                        min_gap[out_idx]    <= sdram_geom_pkg::ACT_LATENCY + 1;
                    end
                    sdram_cmd_pkg::PRECHARGE: begin
                        model_open[out_idx] <= 1'b0;
                        min_gap[out_idx]    <= sdram_geom_pkg::PRE_LATENCY + 1;
                    end
                    default: begin
                        min_gap[out_idx] <= 0;
                        completed        <= completed + 1;
                        if (exp_avail) begin
                            sb_head[out_idx] <= sb_head[out_idx] + 1;
                        end
                    end
                endcase
            end
        end
    end

    a_reset_idle: assert property (@(posedge clk_in) disable iff (rst_in)
        quiet_phase |-> !ack && !valid_out)
        else report_mismatch("reset_idle", 0, {$sampled(ack), $sampled(valid_out)});
    a_ack_rise: assert property (@(posedge clk_in) disable iff (rst_in)
        $rose(ack) |-> $past(req))
        else report_failure("ack rose while req was low");
    a_ack_fall: assert property (@(posedge clk_in) disable iff (rst_in)
        $fell(ack) |-> !$past(req))
        else report_failure("ack fell before req was released");
    a_full_hold: assert property (@(posedge clk_in) disable iff (rst_in)
        expect_no_ack |-> !ack)
        else report_mismatch("full_queue_ack", 0, $sampled(ack));
    a_act_closed: assert property (@(posedge clk_in) disable iff (rst_in)
        valid_out && cmd_out == sdram_cmd_pkg::ACTIVATE |-> !open_at_out)
        else report_failure("activate sent to a bank that is already open");
    a_pre_open: assert property (@(posedge clk_in) disable iff (rst_in)
        valid_out && cmd_out == sdram_cmd_pkg::PRECHARGE |-> open_at_out)
        else report_failure("precharge sent to a closed bank");
    a_col_open: assert property (@(posedge clk_in) disable iff (rst_in)
        col_cmd |-> open_at_out)
        else report_failure("read or write sent to a closed bank");
    a_col_row: assert property (@(posedge clk_in) disable iff (rst_in)
        col_cmd && open_at_out |-> row_out == row_at_out)
        else report_mismatch("row_hit", $sampled(row_at_out), $sampled(row_out));
    a_latency: assert property (@(posedge clk_in) disable iff (rst_in)
        valid_out |-> gap_out >= min_gap_out)
        else report_mismatch("bank_latency", $sampled(min_gap_out), $sampled(gap_out));
    a_sb_pending: assert property (@(posedge clk_in) disable iff (rst_in)
        col_cmd |-> exp_avail)
        else report_failure("read or write with no accepted request left for its bank");
    a_sb_order: assert property (@(posedge clk_in) disable iff (rst_in)
        col_cmd && exp_avail |-> act_word == exp_word)
        else report_mismatch("completion_order", $sampled(exp_word), $sampled(act_word));
    a_backpressure: assert property (@(posedge clk_in) disable iff (rst_in)
        !cmd_ready |=> !valid_out)
        else report_mismatch("backpressure", 0, $sampled(valid_out));

    initial begin
        logic [15:0] r;
        int n;
        clk_in        = 1'b0;
        rst_in        <= 1'b1;
        req           <= 1'b0;
        bank_group_in <= '0;
        bank_in       <= '0;
        row_in        <= '0;
        col_in        <= '0;
        write_in      <= 1'b0;
        val_in        <= '0;
        cmd_ready     <= 1'b0;   // Controller stalled until the full-queue test is done
        quiet_phase   <= 1'b0;
        expect_no_ack <= 1'b0;
        rand_ready    = 1'b0;
        timeout_hit   = 1'b0;
        lfsr          = SEED;
        accepted      = 0;
        err_count     = 0;
        for (int b = 0; b < sdram_geom_pkg::BANKS; b++) begin
            sb_tail[b] <= 0;
        end
        repeat (3) @(posedge clk_in);
        rst_in      <= 1'b0;
        quiet_phase <= 1'b1;
        repeat (4) step_cycle();
        quiet_phase <= 1'b0;

        // Fill bank 0 so one more request has to wait for the controller
        for (int i = 0; i < sdram_geom_pkg::QUEUE_DEPTH; i++) begin
            present_req('0);
            wait_for_ack();
            release_req();
        end
        present_req('0);
        expect_no_ack <= 1'b1;
        repeat (FILL_WAIT) step_cycle();
        expect_no_ack <= 1'b0;
        cmd_ready     <= 1'b1;
        rand_ready    = 1'b1;
        wait_for_ack();
        release_req();

        for (int i = sdram_geom_pkg::QUEUE_DEPTH + 1; i < NUM_REQ; i++) begin
            draw_bits(sdram_geom_pkg::BANK_IDX_W, r);
            present_req(r[sdram_geom_pkg::BANK_IDX_W-1:0]);
            wait_for_ack();
            release_req();
        end

        n = 0;
        while (!timeout_hit && completed != accepted && n < DRAIN_TIMEOUT) begin
            step_cycle();
            n++;
        end
        if (!timeout_hit && completed != accepted) begin
            $display("Timeout: %0d of %0d requests still outstanding after %0d cycles",
                     accepted - completed, accepted, DRAIN_TIMEOUT);
            timeout_hit = 1'b1;
        end
        if (!timeout_hit) begin
            repeat (10) step_cycle();   // Catch any stray command after the drain
        end
        finish_run(timeout_hit);
    end

endmodule

// File: src/sdram_sched_top.sv
// SDRAM command scheduler top: host intake, per-bank queues, bank tracker and command arbiter
`timescale 1ns/10ps

module sdram_sched_top (
    input  logic                                clk_in,
    input  logic                                rst_in,
    input  logic                                req,
    input  logic [sdram_geom_pkg::BG_W-1:0]     bank_group_in,
    input  logic [sdram_geom_pkg::BA_W-1:0]     bank_in,
    input  logic [sdram_geom_pkg::ROW_BITS-1:0] row_in,
    input  logic [sdram_geom_pkg::COL_BITS-1:0] col_in,
    input  logic                                write_in,
    input  logic [sdram_geom_pkg::DATA_W-1:0]   val_in,
    input  logic                                cmd_ready,
    output logic                                ack,
    output logic [sdram_geom_pkg::BG_W-1:0]     bank_group_out,
    output logic [sdram_geom_pkg::BA_W-1:0]     bank_out,
    output logic [sdram_geom_pkg::ROW_BITS-1:0] row_out,
    output logic [sdram_geom_pkg::COL_BITS-1:0] col_out,
    output logic [sdram_geom_pkg::DATA_W-1:0]   val_out,
    output sdram_cmd_pkg::cmd_t                 cmd_out,
    output logic                                valid_out
);

    logic [sdram_geom_pkg::BANKS-1:0]                               push;
    logic [sdram_geom_pkg::BANKS-1:0]                               full;
    logic [sdram_geom_pkg::BANKS-1:0]                               empty;
    logic [sdram_geom_pkg::BANKS-1:0]                               pop;
    logic [sdram_geom_pkg::BANKS-1:0]                               act;
    logic [sdram_geom_pkg::BANKS-1:0]                               pre;
    logic [sdram_geom_pkg::BANKS-1:0]                               open;
    logic [sdram_geom_pkg::BANKS-1:0]                               busy;
    logic [sdram_geom_pkg::ROW_BITS-1:0]                            act_row;
    logic [sdram_geom_pkg::BANKS-1:0][sdram_geom_pkg::ROW_BITS-1:0] open_row;
    sdram_cmd_pkg::req_t                                            push_req;
    sdram_cmd_pkg::req_t [sdram_geom_pkg::BANKS-1:0]                head;

    host_intake i_intake (
        .clk_in        (clk_in),
        .rst_in        (rst_in),
        .req           (req),
        .bank_group_in (bank_group_in),
        .bank_in       (bank_in),
        .row_in        (row_in),
        .col_in        (col_in),
        .write_in      (write_in),
        .val_in        (val_in),
        .full          (full),
        .ack           (ack),
        .push          (push),
        .push_req      (push_req)
    );

    // One queue per flat bank index
    for (genvar i = 0; i < sdram_geom_pkg::BANKS; i++) begin : g_queue
        bank_queue i_queue (
            .clk_in   (clk_in),
            .rst_in   (rst_in),
            .push     (push[i]),
            .pop      (pop[i]),
            .push_req (push_req),
            .head     (head[i]),
            .empty    (empty[i]),
            .full     (full[i])
        );
    end

    bank_tracker i_tracker (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .act      (act),
        .pre      (pre),
        .act_row  (act_row),
        .open     (open),
        .busy     (busy),
        .open_row (open_row)
    );

    cmd_arbiter i_arbiter (
        .clk_in         (clk_in),
        .rst_in         (rst_in),
        .cmd_ready      (cmd_ready),
        .head           (head),
        .empty          (empty),
        .open           (open),
        .busy           (busy),
        .open_row       (open_row),
        .pop            (pop),
        .act            (act),
        .pre            (pre),
        .act_row        (act_row),
        .bank_group_out (bank_group_out),
        .bank_out       (bank_out),
        .row_out        (row_out),
        .col_out        (col_out),
        .val_out        (val_out),
        .cmd_out        (cmd_out),
        .valid_out      (valid_out)
    );

endmodule

// File: src/cmd_arbiter.sv
// Command arbiter that works out the next command per bank head and drives the shared command bus
`timescale 1ns/10ps

module cmd_arbiter (
    input  logic                                         clk_in,
    input  logic                                         rst_in,
    input  logic                                         cmd_ready,
    input  sdram_cmd_pkg::req_t [sdram_geom_pkg::BANKS-1:0] head,
    input  logic [sdram_geom_pkg::BANKS-1:0]             empty,
    input  logic [sdram_geom_pkg::BANKS-1:0]             open,
    input  logic [sdram_geom_pkg::BANKS-1:0]             busy,
    input  logic [sdram_geom_pkg::BANKS-1:0][sdram_geom_pkg::ROW_BITS-1:0] open_row,
    output logic [sdram_geom_pkg::BANKS-1:0]             pop,
    output logic [sdram_geom_pkg::BANKS-1:0]             act,
    output logic [sdram_geom_pkg::BANKS-1:0]             pre,
    output logic [sdram_geom_pkg::ROW_BITS-1:0]          act_row,
    output logic [sdram_geom_pkg::BG_W-1:0]              bank_group_out,
    output logic [sdram_geom_pkg::BA_W-1:0]              bank_out,
    output logic [sdram_geom_pkg::ROW_BITS-1:0]          row_out,
    output logic [sdram_geom_pkg::COL_BITS-1:0]          col_out,
    output logic [sdram_geom_pkg::DATA_W-1:0]            val_out,
    output sdram_cmd_pkg::cmd_t                          cmd_out,
    output logic                                         valid_out
);

    logic [sdram_geom_pkg::BANKS-1:0]      col_req;  // Row hit and ready for read/write
    logic [sdram_geom_pkg::BANKS-1:0]      act_req;  // Bank closed
    logic [sdram_geom_pkg::BANKS-1:0]      pre_req;  // Row miss
    logic [sdram_geom_pkg::BANKS-1:0]      cls;      // Winning class
    logic [sdram_geom_pkg::BANKS-1:0]      grant;
    logic [sdram_geom_pkg::BANK_IDX_W-1:0] sel;
    sdram_cmd_pkg::req_t                   sel_req;
    sdram_cmd_pkg::cmd_t                   pick_cmd;
    logic                                  go;

    // Classify every head whose bank is idle
    always_comb begin
        for (int b = 0; b < sdram_geom_pkg::BANKS; b++) begin
            col_req[b] = !empty[b] && !busy[b] && open[b] && (open_row[b] == head[b].row);
            act_req[b] = !empty[b] && !busy[b] && !open[b];
            pre_req[b] = !empty[b] && !busy[b] && open[b] && (open_row[b] != head[b].row);
        end
    end

    // Column commands first, then activate, then precharge; lowest bank wins in a class
    always_comb begin
        if (|col_req) begin
            cls = col_req;
        end else if (|act_req) begin
            cls = act_req;
        end else begin
            cls = pre_req;
        end
        sel = '0;
        for (int b = sdram_geom_pkg::BANKS - 1; b >= 0; b--) begin
            if (cls[b]) begin
                sel = b[sdram_geom_pkg::BANK_IDX_W-1:0];
            end
        end
    end

    assign sel_req = head[sel];
    assign go      = cmd_ready && (|cls);

    always_comb begin
        if (|col_req) begin
            pick_cmd = sel_req.write ? sdram_cmd_pkg::WRITE : sdram_cmd_pkg::READ;
        end else if (|act_req) begin
            pick_cmd = sdram_cmd_pkg::ACTIVATE;
        end else begin
            pick_cmd = sdram_cmd_pkg::PRECHARGE;
        end
    end

    always_comb begin
        grant      = '0;
        grant[sel] = go;
    end

    // Classes are exclusive per bank, so only one of these can fire
    assign pop     = grant & col_req;   // Request leaves its queue only on read/write
    assign act     = grant & act_req;
    assign pre     = grant & pre_req;
    assign act_row = sel_req.row;

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            valid_out <= 1'b0;
        end else begin
            valid_out <= go;
        end
    end

    always_ff @(posedge clk_in) begin
        if (go) begin
            bank_group_out <= sel[sdram_geom_pkg::BANK_IDX_W-1:sdram_geom_pkg::BA_W];
            bank_out       <= sel[sdram_geom_pkg::BA_W-1:0];
            row_out        <= sel_req.row;
            col_out        <= sel_req.col;
            cmd_out        <= pick_cmd;
            val_out        <= (pick_cmd == sdram_cmd_pkg::WRITE) ? sel_req.data : '0;
        end
    end

    // One grant per cycle across pop, act and pre
    property p_single_grant;
        @(posedge clk_in) disable iff (rst_in)
            $onehot0({pop, act, pre});
    endproperty
    a_single_grant: assert property (p_single_grant)
        else $error("cmd_arbiter: more than one grant in a cycle");

endmodule

// File: src/bank_tracker.sv
// Bank state tracker: open flag, open row and busy countdown for every bank
`timescale 1ns/10ps

module bank_tracker (
    input  logic                                                      clk_in,
    input  logic                                                      rst_in,
    input  logic [sdram_geom_pkg::BANKS-1:0]                          act,
    input  logic [sdram_geom_pkg::BANKS-1:0]                          pre,
    input  logic [sdram_geom_pkg::ROW_BITS-1:0]                       act_row,
    output logic [sdram_geom_pkg::BANKS-1:0]                          open,
    output logic [sdram_geom_pkg::BANKS-1:0]                          busy,
    output logic [sdram_geom_pkg::BANKS-1:0][sdram_geom_pkg::ROW_BITS-1:0] open_row
);

    logic [sdram_geom_pkg::BANKS-1:0][sdram_geom_pkg::TIMER_W-1:0] timer;

    // Open flag and countdown per bank
    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            open  <= '0;
            timer <= '0;
        end else begin
            for (int b = 0; b < sdram_geom_pkg::BANKS; b++) begin
                if (act[b]) begin
                    open[b]  <= 1'b1;
                    timer[b] <= sdram_geom_pkg::ACT_LATENCY[sdram_geom_pkg::TIMER_W-1:0];
                end else if (pre[b]) begin
                    open[b]  <= 1'b0;
                    timer[b] <= sdram_geom_pkg::PRE_LATENCY[sdram_geom_pkg::TIMER_W-1:0];
                end else if (timer[b] != '0) begin
                    timer[b] <= timer[b] - 1'b1;
                end
            end
        end
    end

    // Row is only meaningful while the bank is open
    always_ff @(posedge clk_in) begin
        for (int b = 0; b < sdram_geom_pkg::BANKS; b++) begin
            if (act[b]) begin
                open_row[b] <= act_row;
            end
        end
    end

    always_comb begin
        for (int b = 0; b < sdram_geom_pkg::BANKS; b++) begin
            busy[b] = (timer[b] != '0);
        end
    end

    // Arbiter must respect the latency window reported back to it
    property p_no_cmd_to_busy;
        @(posedge clk_in) disable iff (rst_in)
            ((act | pre) & busy) == '0;
    endproperty
    a_no_cmd_to_busy: assert property (p_no_cmd_to_busy)
        else $error("bank_tracker: activate or precharge sent to a busy bank");

endmodule

// File: src/bank_queue.sv
// Per-bank request FIFO that keeps requests in arrival order and shows its head
`timescale 1ns/10ps

module bank_queue (
    input  logic                clk_in,
    input  logic                rst_in,
    input  logic                push,
    input  logic                pop,
    input  sdram_cmd_pkg::req_t push_req,
    output sdram_cmd_pkg::req_t head,
    output logic                empty,
    output logic                full
);

    sdram_cmd_pkg::req_t mem [sdram_geom_pkg::QUEUE_DEPTH];

    logic [$clog2(sdram_geom_pkg::QUEUE_DEPTH)-1:0] head_ptr;
    logic [$clog2(sdram_geom_pkg::QUEUE_DEPTH)-1:0] wr_ptr;
    logic [$clog2(sdram_geom_pkg::QUEUE_DEPTH):0]   count;   // One extra bit for full
    logic                                           do_push;
    logic                                           do_pop;

    assign empty = (count == 0);
    assign full  = (count == sdram_geom_pkg::QUEUE_DEPTH);

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign wr_ptr = head_ptr + count[$bits(head_ptr)-1:0]; // Wraps with the power-of-two depth
    assign head   = mem[head_ptr];

    always_ff @(posedge clk_in) begin
        if (do_push) begin
            mem[wr_ptr] <= push_req;
        end
    end

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            head_ptr <= '0;
            count    <= '0;
        end else begin
            if (do_pop) begin
                head_ptr <= head_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // Idle, or push and pop together
            endcase
        end
    end

    // Arbiter only pops a queue it saw non-empty
    a_no_pop_empty: assert property (@(posedge clk_in) disable iff (rst_in) !(pop && empty))
        else $error("bank_queue: pop while empty");

    // Intake holds off on a full queue
    a_no_push_full: assert property (@(posedge clk_in) disable iff (rst_in) !(push && full))
        else $error("bank_queue: push while full");

endmodule

// File: src/host_intake.sv
// Host request intake: four-phase req/ack handshake that routes each request to its bank queue
`timescale 1ns/10ps

module host_intake (
    input  logic                                  clk_in,
    input  logic                                  rst_in,
    input  logic                                  req,
    input  logic [sdram_geom_pkg::BG_W-1:0]       bank_group_in,
    input  logic [sdram_geom_pkg::BA_W-1:0]       bank_in,
    input  logic [sdram_geom_pkg::ROW_BITS-1:0]   row_in,
    input  logic [sdram_geom_pkg::COL_BITS-1:0]   col_in,
    input  logic                                  write_in,
    input  logic [sdram_geom_pkg::DATA_W-1:0]     val_in,
    input  logic [sdram_geom_pkg::BANKS-1:0]      full,
    output logic                                  ack,
    output logic [sdram_geom_pkg::BANKS-1:0]      push,
    output sdram_cmd_pkg::req_t                   push_req
);

    logic [sdram_geom_pkg::BANK_IDX_W-1:0] bank_idx;
    logic                                  take; // Accept on this edge

    assign bank_idx = {bank_group_in, bank_in}; // Group major

    // ack low is the idle state, ack high waits for req to drop
    assign take = req && !ack && !full[bank_idx];

    always_comb begin
        push           = '0;
        push[bank_idx] = take;
    end

    assign push_req.row   = row_in;
    assign push_req.col   = col_in;
    assign push_req.write = write_in;
    assign push_req.data  = val_in;

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            ack <= 1'b0;
        end else if (take) begin
            ack <= 1'b1;             // Raised together with the push
        end else if (ack && !req) begin
            ack <= 1'b0;             // Host has seen ack and released req
        end
    end

    // A rising ack must come from a request that was present at the push
    property p_ack_needs_req;
        @(posedge clk_in) disable iff (rst_in)
            $rose(ack) |-> $past(req);
    endproperty
    a_ack_needs_req: assert property (p_ack_needs_req)
        else $error("host_intake: ack rose without a pending req");

endmodule

// File: src/sdram_cmd_pkg.sv
// SDRAM command encoding and the request word held in the bank queues
package sdram_cmd_pkg;

    // Command bus encoding, matches the controller side
    typedef enum logic [1:0] {
        READ      = 2'd0,
        WRITE     = 2'd1,
        ACTIVATE  = 2'd2,
        PRECHARGE = 2'd3
    } cmd_t;

    // One queued request
    // Bank is implied by the queue that holds it
    typedef struct packed {
        logic [sdram_geom_pkg::ROW_BITS-1:0] row;
        logic [sdram_geom_pkg::COL_BITS-1:0] col;
        logic                                write;  // 1 = write, 0 = read
        logic [sdram_geom_pkg::DATA_W-1:0]   data;   // Write data, don't care on reads
    } req_t;

endpackage

// File: src/sdram_geom_pkg.sv
// SDRAM scheduler geometry: bank layout, address and data widths, queue depth and bank timing
package sdram_geom_pkg;

    // Bank organisation
    localparam int BANK_GROUPS     = 2;
    localparam int BANKS_PER_GROUP = 2;
    localparam int BANKS           = BANK_GROUPS * BANKS_PER_GROUP;

    localparam int BG_W       = $clog2(BANK_GROUPS);     // Bank group field
    localparam int BA_W       = $clog2(BANKS_PER_GROUP); // Bank field inside a group
    localparam int BANK_IDX_W = BG_W + BA_W;             // Flat index {group, bank}

    // Address and data
    localparam int ROW_BITS = 8;
    localparam int COL_BITS = 4;
    localparam int DATA_W   = 16;

    localparam int QUEUE_DEPTH = 4; // Entries per bank queue

    // Cycles a bank stays busy after the command
    localparam int ACT_LATENCY = 8;
    localparam int PRE_LATENCY = 5;

    // Busy countdown must hold the longer of the two latencies
    localparam int TIMER_W =
        $clog2((ACT_LATENCY > PRE_LATENCY ? ACT_LATENCY : PRE_LATENCY) + 1);

endpackage
